// File: aes_dec_core.f
+incdir+tests
src/aes_types_pkg.sv
src/aes_ctrl_pkg.sv
src/dec_step_if.sv
src/inv_sbox_rom.sv
src/inv_sub_shift.sv
src/inv_mix_columns.sv
src/dec_round_datapath.sv
src/dec_controller.sv
src/aes_dec_core.sv
tests/aes_dec_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
# A build or run error also leaves the fail message in the log
cd "$(dirname "$0")" || exit 1
log=sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module aes_dec_core_tb -f aes_dec_core.f > "$log" 2>&1 \
    && ./obj_dir/Vaes_dec_core_tb >> "$log" 2>&1 \
    || echo "Test failures found" >> "$log"
cat "$log"
grep -q "Test failures found" "$log" && exit 1 || exit 0

// File: src/aes_ctrl_pkg.sv
package aes_ctrl_pkg;

    // Round sequencer states
    // sub waits for the byte walk, key applies the round key
    typedef enum logic [1:0]
    {
        idle,
        sub,
        key,
        done
    } dec_state_t;

    // Bytes in one AES state, one ROM lookup each
    localparam int state_bytes = 16;

    // Cycles from sub_start to sub_done, one extra for the ROM register
    localparam int sub_latency = state_bytes + 1;

endpackage

// File: src/aes_dec_core.sv
module aes_dec_core #(
    parameter int num_rounds = 14
)
(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      in_valid,
    input  aes_types_pkg::block_t     data_in,
    input  aes_types_pkg::round_key_t key,
    output aes_types_pkg::key_idx_t   key_addr,
    output aes_types_pkg::block_t     data_out,
    output logic                      out_valid,
    output logic                      busy
);

    // Step strobes between sequencer and datapath
    dec_step_if step ();

    dec_controller #(
        .num_rounds (num_rounds)
    ) u_ctrl
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .step      (step.ctrl),
        .key_addr  (key_addr),
        .out_valid (out_valid),
        .busy      (busy)
    );

    // External key lookup feeds the datapath directly
    dec_round_datapath u_dp
    (
        .clk      (clk),
        .resetn   (resetn),
        .step     (step.dp),
        .data_in  (data_in),
        .key      (key),
        .data_out (data_out)
    );

endmodule

// File: src/aes_types_pkg.sv
package aes_types_pkg;

    // One state byte
    typedef logic [7:0] byte_t;

    // AES state as 16 bytes, byte 0 is the top byte
    // Bytes run column by column, index = 4 * column + row
    typedef byte_t [0:15] state_t;

    // Flat data block as seen on the ports
    typedef logic [127:0] block_t;

    // One round key, same byte order as the state
    typedef logic [127:0] round_key_t;

    // Round key index, 0 up to 14 for AES-256
    typedef logic [3:0] key_idx_t;

endpackage

// File: src/dec_controller.sv
module dec_controller #(
    parameter int num_rounds = 14
)
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    in_valid,
    dec_step_if.ctrl                step,
    output aes_types_pkg::key_idx_t key_addr,
    output logic                    out_valid,
    output logic                    busy
);

    import aes_types_pkg::*;
    import aes_ctrl_pkg::*;

    dec_state_t state;
    logic       last_key;

    // Accept a block only when idle, key Nr is already on the port
    assign step.load = (state == idle) && in_valid;

    // One cycle per round in key
    assign step.key_step = (state == key);

    // Index 0 marks the final round, no column mix
    assign last_key    = (key_addr == '0);
    assign step.mix_en = !last_key;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state          <= idle;
            key_addr       <= key_idx_t'(num_rounds);
            step.sub_start <= 1'b0;
            out_valid      <= 1'b0;
            busy           <= 1'b0;
        end
        else
        begin
            // Strobes default low
            step.sub_start <= 1'b0;
            out_valid      <= 1'b0;
            case (state)
                idle:
                begin
                    if (in_valid)
                    begin
                        state          <= sub;
                        step.sub_start <= 1'b1;
                        busy           <= 1'b1;
                        // Next key in place well before the first key step
                        key_addr       <= key_addr - 1'b1;
                    end
                end
                sub:
                begin
                    if (step.sub_done)
                        state <= key;
                end
                key:
                begin
                    if (last_key)
                    begin
                        state     <= done;
                        out_valid <= 1'b1;
                        busy      <= 1'b0;
                        key_addr  <= key_idx_t'(num_rounds);
                    end
                    else
                    begin
                        state          <= sub;
                        step.sub_start <= 1'b1;
                        key_addr       <= key_addr - 1'b1;
                    end
                end
                done:
                begin
                    state <= idle;
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    a_no_start_idle: assert property (@(posedge clk) disable iff (!resetn)
        step.sub_start |-> state != idle);

    a_key_range: assert property (@(posedge clk) disable iff (!resetn)
        key_addr <= num_rounds);

    // Substitution unit answers only while we wait for it
    a_done_in_sub: assert property (@(posedge clk) disable iff (!resetn)
        step.sub_done |-> state == sub);

    // Fixed walk length through the datapath ROM
    a_sub_latency: assert property (@(posedge clk) disable iff (!resetn)
        step.sub_start |-> ##sub_latency step.sub_done);

endmodule

// File: src/dec_round_datapath.sv
module dec_round_datapath
(
    input  logic                      clk,
    input  logic                      resetn,
    dec_step_if.dp                    step,
    input  aes_types_pkg::block_t     data_in,
    input  aes_types_pkg::round_key_t key,
    output aes_types_pkg::block_t     data_out
);

    import aes_types_pkg::*;

    state_t state_q;
    state_t sub_out;
    state_t add_out;
    state_t mix_out;

    // InvShiftRows and InvSubBytes over the held state
    inv_sub_shift u_sub
    (
        .clk       (clk),
        .resetn    (resetn),
        .start     (step.sub_start),
        .state_in  (state_q),
        .state_out (sub_out),
        .done      (step.sub_done)
    );

    // AddRoundKey before the column mix
    assign add_out = sub_out ^ key;

    inv_mix_columns u_mix
    (
        .state_in  (add_out),
        .state_out (mix_out)
    );

    // Round state
    // load takes the first key addition, key_step the round result
    always_ff @(posedge clk)
    begin
        if (step.load)
            state_q <= data_in ^ key;
        else if (step.key_step)
            state_q <= step.mix_en ? mix_out : add_out;
    end

    // Output register, only the final round writes it
    // Holds until the next block finishes
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            data_out <= '0;
        else if (step.key_step && !step.mix_en)
            data_out <= add_out;
    end

endmodule

// File: src/dec_step_if.sv
interface dec_step_if;

    // Load the new block, one cycle
    logic load;

    // Start of the byte-serial substitution, one cycle
    logic sub_start;

    // Apply round key and take the round result, one cycle
    logic key_step;

    // Level, valid with key_step
    // Low only on the final round
    logic mix_en;

    // Last substituted byte written, one cycle
    logic sub_done;

    modport ctrl
    (
        output load, sub_start, key_step, mix_en,
        input  sub_done
    );

    modport dp
    (
        input  load, sub_start, key_step, mix_en,
        output sub_done
    );

endinterface

// File: src/inv_mix_columns.sv
module inv_mix_columns
(
    input  aes_types_pkg::state_t state_in,
    output aes_types_pkg::state_t state_out
);

    import aes_types_pkg::*;

    // Multiply by x in GF(2^8), reduction poly 0x11b
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Product with a 4-bit coefficient
    // Sum of b, 2b, 4b, 8b picked by the coefficient bits
    function automatic byte_t gmul(input byte_t b, input logic [3:0] c);
        byte_t x2;
        byte_t x4;
        byte_t x8;
        x2 = xtime(b);
        x4 = xtime(x2);
        x8 = xtime(x4);
        return (c[0] ? b : 8'h00) ^ (c[1] ? x2 : 8'h00) ^
               (c[2] ? x4 : 8'h00) ^ (c[3] ? x8 : 8'h00);
    endfunction

    // Inverse matrix rows are rotations of 0e 0b 0d 09
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            state_out[4 * c + 0] = gmul(state_in[4 * c + 0], 4'he) ^
                                   gmul(state_in[4 * c + 1], 4'hb) ^
                                   gmul(state_in[4 * c + 2], 4'hd) ^
                                   gmul(state_in[4 * c + 3], 4'h9);
            state_out[4 * c + 1] = gmul(state_in[4 * c + 0], 4'h9) ^
                                   gmul(state_in[4 * c + 1], 4'he) ^
                                   gmul(state_in[4 * c + 2], 4'hb) ^
                                   gmul(state_in[4 * c + 3], 4'hd);
            state_out[4 * c + 2] = gmul(state_in[4 * c + 0], 4'hd) ^
                                   gmul(state_in[4 * c + 1], 4'h9) ^
                                   gmul(state_in[4 * c + 2], 4'he) ^
                                   gmul(state_in[4 * c + 3], 4'hb);
            state_out[4 * c + 3] = gmul(state_in[4 * c + 0], 4'hb) ^
                                   gmul(state_in[4 * c + 1], 4'hd) ^
                                   gmul(state_in[4 * c + 2], 4'h9) ^
                                   gmul(state_in[4 * c + 3], 4'he);
        end
    end

endmodule

// File: src/inv_sbox_rom.sv
module inv_sbox_rom
(
    input  logic                clk,
    input  aes_types_pkg::byte_t addr,
    output aes_types_pkg::byte_t data
);

    import aes_types_pkg::*;

    // Inverse S-box, entry 0 in the top byte
    // One row of 16 entries per literal
    localparam byte_t [0:255] inv_sbox =
    {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    // Registered read, block ROM style
    always_ff @(posedge clk)
    begin
        data <= inv_sbox[addr];
    end

endmodule

// File: src/inv_sub_shift.sv
module inv_sub_shift
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  aes_types_pkg::state_t state_in,
    output aes_types_pkg::state_t state_out,
    output logic                  done
);

    import aes_types_pkg::*;
    import aes_ctrl_pkg::*;

    state_t                          shifted;
    state_t                          work;
    byte_t                           rom_addr;
    byte_t                           rom_data;
    logic                            walking;
    logic                            wr_pending;
    logic [$clog2(state_bytes)-1:0]  rd_idx;
    logic [$clog2(state_bytes)-1:0]  wr_idx;

    // InvShiftRows, row r rotates right by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[4 * c + r] = state_in[4 * ((c + 4 - r) % 4) + r];
            end
        end
    end

    // Byte under lookup
    assign rom_addr = work[rd_idx];

    inv_sbox_rom u_rom
    (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    // Read walk, write side trails by the ROM delay
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            walking    <= 1'b0;
            wr_pending <= 1'b0;
            rd_idx     <= '0;
            wr_idx     <= '0;
        end
        else
        begin
            wr_pending <= walking;
            wr_idx     <= rd_idx;
            if (start)
            begin
                walking <= 1'b1;
                rd_idx  <= '0;
            end
            else if (walking)
            begin
                // Last address issued
                if (rd_idx == state_bytes - 1)
                    walking <= 1'b0;
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    // Working copy, substituted in place one byte per cycle
    always_ff @(posedge clk)
    begin
        if (start)
            work <= shifted;
        else if (wr_pending)
            work[wr_idx] <= rom_data;
    end

    assign state_out = work;

    // High while the last byte goes in
    assign done = wr_pending && (wr_idx == state_bytes - 1);

    // Controller only restarts after the previous walk has drained
    a_no_restart: assert property (@(posedge clk) disable iff (!resetn)
        start |-> !walking && !wr_pending);

endmodule

// File: tests/aes_model.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// Reference AES encryption after FIPS-197
// Round key i sits in entry i
typedef logic [14:0][127:0] key_sched_t;

// Byte 0 of a block in the top bits, index = 4 * column + row
typedef logic [0:15][7:0] model_state_t;

// Multiply by x, reduction poly 0x11b
function automatic logic [7:0] mul_x(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

// Shift and add product in GF(2^8)
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] aa;
    p  = 8'h00;
    aa = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
            p = p ^ aa;
        aa = mul_x(aa);
    end
    return p;
endfunction

// Forward S-box computed as b^254 followed by the affine map
// Zero maps to zero before the affine step
function automatic logic [7:0] sbox(input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] inv;
    p   = b;
    inv = 8'h01;
    for (int i = 1; i < 8; i++)
    begin
        p   = gf_mul(p, p);
        inv = gf_mul(inv, p);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

function automatic logic [31:0] sub_word(input logic [31:0] w);
    return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
endfunction

// AES-256 key schedule, 60 words into 15 round keys
function automatic key_sched_t expand_key256(input logic [255:0] k);
    logic [31:0] w [0:59];
    logic [31:0] t;
    logic [7:0]  rcon;
    key_sched_t  rk;
    rcon = 8'h01;
    for (int i = 0; i < 8; i++)
        w[i] = k[255 - 32 * i -: 32];
    for (int i = 8; i < 60; i++)
    begin
        t = w[i - 1];
        if (i % 8 == 0)
        begin
            // RotWord then SubWord then Rcon on the top byte
            t    = sub_word({t[23:0], t[31:24]}) ^ {rcon, 24'h0};
            rcon = mul_x(rcon);
        end
        else if (i % 8 == 4)
            t = sub_word(t);
        w[i] = w[i - 8] ^ t;
    end
    for (int r = 0; r < 15; r++)
        rk[r] = {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
    return rk;
endfunction

// Forward cipher with nr rounds
function automatic logic [127:0] encrypt_block(input logic [127:0] pt,
                                               input key_sched_t rk, input int nr);
    model_state_t s;
    model_state_t t;
    logic [7:0]   a0;
    logic [7:0]   a1;
    logic [7:0]   a2;
    logic [7:0]   a3;
    s = pt ^ rk[0];
    for (int r = 1; r <= nr; r++)
    begin
        // SubBytes and ShiftRows together, row n rotates left by n
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
                t[4 * c + row] = sbox(s[4 * ((c + row) % 4) + row]);
        end
        s = t;
        // No MixColumns in the last round
        if (r != nr)
        begin
            for (int c = 0; c < 4; c++)
            begin
                a0 = s[4 * c];
                a1 = s[4 * c + 1];
                a2 = s[4 * c + 2];
                a3 = s[4 * c + 3];
                t[4 * c]     = gf_mul(a0, 8'h02) ^ gf_mul(a1, 8'h03) ^ a2 ^ a3;
                t[4 * c + 1] = a0 ^ gf_mul(a1, 8'h02) ^ gf_mul(a2, 8'h03) ^ a3;
                t[4 * c + 2] = a0 ^ a1 ^ gf_mul(a2, 8'h02) ^ gf_mul(a3, 8'h03);
                t[4 * c + 3] = gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ gf_mul(a3, 8'h02);
            end
            s = t;
        end
        s = s ^ rk[r];
    end
    return s;
endfunction

`endif

// File: tests/aes_dec_core_tb.sv
module aes_dec_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import aes_types_pkg::*;

    `include "aes_model.svh"

    localparam int num_rounds  = 14;
    localparam int timeout_cyc = 1000;

    logic       clk;
    logic       resetn;
    logic       in_valid;
    block_t     data_in;
    round_key_t key = '0;
    key_idx_t   key_addr;
    block_t     data_out;
    logic       out_valid;
    logic       busy;

    // Round keys seen by the DUT, entry i answers key_addr i
    key_sched_t  round_keys = '0;
    logic [31:0] rng_state  = 32'd42615;
    int          errors;
    int          tests_run;

    aes_dec_core #(
        .num_rounds (num_rounds)
    ) aes_dec_core_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .data_in   (data_in),
        .key       (key),
        .key_addr  (key_addr),
        .data_out  (data_out),
        .out_valid (out_valid),
        .busy      (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Key store, answers key_addr one edge later
    always @(posedge clk)
    begin
        key <= round_keys[key_addr];
    end

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic block_t random_block();
        block_t b;
        for (int i = 0; i < 4; i++)
            b[32 * i +: 32] = next_rand();
        return b;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // One-cycle in_valid strobe with the block
    task automatic send_block(input block_t blk);
        @(posedge clk);
        data_in  <= blk;
        in_valid <= 1'b1;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // Sampled on rising edges, so out_valid and data_out are settled
    task automatic wait_result(input string name, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < timeout_cyc)
        begin
            @(posedge clk);
            seen = out_valid;
            n++;
        end
        if (!seen)
        begin
            $display("%s: no out_valid within %0d cycles", name, timeout_cyc);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        $display("%s: %s", name, (errors == err_start) ? "ok" : "failed");
    endtask

    task automatic check_reset_values();
        int err_start;
        err_start = errors;
        @(posedge clk);
        if (out_valid !== 1'b0)
        begin
            $display("Fail at %0t: out_valid expected 0, got %b", $time, out_valid);
            errors++;
        end
        if (busy !== 1'b0)
        begin
            $display("Fail at %0t: busy expected 0, got %b", $time, busy);
            errors++;
        end
        if (key_addr !== 4'd14)
        begin
            $display("Fail at %0t: key_addr expected 14, got %0d", $time, key_addr);
            errors++;
        end
        if (data_out !== '0)
        begin
            $display("Fail at %0t: data_out expected 0, got %h", $time, data_out);
            errors++;
        end
        report_test("reset values", err_start);
    endtask

    // FIPS-197 AES-256 example vector
    task automatic decrypt_known_answer();
        int   err_start;
        logic seen;
        err_start = errors;
        @(posedge clk);
        round_keys <= expand_key256(
            256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f);
        idle_cycles(2);
        send_block(128'h8ea2b7ca516745bfeafc49904b496089);
        wait_result("known answer", seen);
        if (seen && data_out !== 128'h00112233445566778899aabbccddeeff)
        begin
            $display("Fail at %0t: data_out expected %h, got %h", $time,
                     128'h00112233445566778899aabbccddeeff, data_out);
            errors++;
        end
        // busy drops with the result
        if (seen && busy !== 1'b0)
        begin
            $display("Fail at %0t: busy expected 0, got %b", $time, busy);
            errors++;
        end
        report_test("known answer", err_start);
    endtask

    task automatic round_trip_blocks();
        int         err_start;
        logic       seen;
        key_sched_t rk;
        block_t     pt;
        block_t     ct;
        err_start = errors;
        for (int b = 0; b < 20; b++)
        begin
            for (int r = 0; r < 15; r++)
                rk[r] = random_block();
            pt = random_block();
            ct = encrypt_block(pt, rk, num_rounds);
            @(posedge clk);
            round_keys <= rk;
            idle_cycles(2);
            send_block(ct);
            wait_result("round trip", seen);
            if (seen && data_out !== pt)
            begin
                $display("Fail at %0t: data_out expected %h, got %h", $time, pt, data_out);
                errors++;
            end
        end
        report_test("random round trip", err_start);
    endtask

    // Every key index from 14 down to 0 once, then back to 14
    task automatic trace_key_indices();
        int       err_start;
        int       n;
        logic     seen;
        key_idx_t prev;
        key_idx_t trace[$];
        err_start = errors;
        idle_cycles(2);
        prev = key_addr;
        trace.push_back(prev);
        send_block(random_block());
        seen = 1'b0;
        n    = 0;
        while (!seen && n < timeout_cyc)
        begin
            @(posedge clk);
            n++;
            seen = out_valid;
            if (!seen && key_addr != prev)
            begin
                prev = key_addr;
                trace.push_back(prev);
            end
        end
        if (!seen)
        begin
            $display("key index trace: no out_valid within %0d cycles", timeout_cyc);
            errors++;
        end
        if (trace.size() != 15)
        begin
            $display("key_addr took %0d distinct steps instead of 15", trace.size());
            errors++;
        end
        for (int i = 0; i < trace.size() && i < 15; i++)
        begin
            if (trace[i] !== key_idx_t'(14 - i))
            begin
                $display("Fail at %0t: key_addr expected %0d, got %0d", $time, 14 - i,
                         trace[i]);
                errors++;
            end
        end
        if (seen && key_addr !== 4'd14)
        begin
            $display("Fail at %0t: key_addr expected 14, got %0d", $time, key_addr);
            errors++;
        end
        report_test("key index sequence", err_start);
    endtask

    // Second strobe lands while busy and must be dropped
    task automatic ignore_busy_input();
        int     err_start;
        int     n;
        logic   seen;
        logic   extra;
        block_t pt;
        err_start = errors;
        pt = random_block();
        idle_cycles(2);
        send_block(encrypt_block(pt, round_keys, num_rounds));
        idle_cycles(5);
        if (busy !== 1'b1)
        begin
            $display("Fail at %0t: busy expected 1, got %b", $time, busy);
            errors++;
        end
        send_block(random_block());
        wait_result("busy input", seen);
        if (seen && data_out !== pt)
        begin
            $display("Fail at %0t: data_out expected %h, got %h", $time, pt, data_out);
            errors++;
        end
        extra = 1'b0;
        for (n = 0; n < timeout_cyc; n++)
        begin
            @(posedge clk);
            if (out_valid)
                extra = 1'b1;
        end
        if (extra)
        begin
            $display("A block sent while busy produced an extra out_valid");
            errors++;
        end
        report_test("ignored input while busy", err_start);
    endtask

    initial
    begin
        resetn    = 1'b0;
        in_valid  = 1'b0;
        data_in   = '0;
        errors    = 0;
        tests_run = 0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        check_reset_values();
        decrypt_known_answer();
        round_trip_blocks();
        trace_key_indices();
        ignore_busy_input();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
